// File: hazard_defs.svh
/*
  Shared widths and encodings for the fetch-stage hazard unit.
  Include this in any file that needs field widths, opcode values,
  write-back select codes or the NOP word. The package holds the
  instruction word types built on these widths.
*/
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

// instruction word and field widths
`define INST_W    16
`define OPCODE_W  5
`define REG_IDX_W 3

// producer write-back select and forwarding control widths
`define WB_SEL_W  2
`define FWD_W     4

// where a producer stage takes its write-back data from
`define WB_SLBI   2'd0
`define WB_MEM    2'd1
`define WB_ALU    2'd2
`define WB_IMM    2'd3

// stores, both read rs and rd
`define OP_ST     5'b10000
`define OP_STU    5'b10011

// register-register alu groups, read rs and rt
`define OP_ARITH  5'b11011
`define OP_BIT    5'b11010

// immediate load, reads no register
`define OP_LBI    5'b11000

// system group
`define OP_HALT   5'b00000
`define OP_NOP    5'b00001
`define OP_SIIC   5'b00010
`define OP_RTI    5'b00011

// bubble sent to decode on a stall or during reset
`define NOP_INST  {`OP_NOP, {(`INST_W - `OPCODE_W){1'b0}}}

`endif

// File: isa_pkg.sv
/*
  Instruction word types for the 16-bit ISA.
  One packed union gives two views of the same fetched word, the
  register layout and the immediate layout. Modules refer to these
  by scoped name and never import the package.
*/
`default_nettype none

`include "hazard_defs.svh"

package isa_pkg;

    // opcode field, top bits of every word
    typedef logic [`OPCODE_W-1:0] opcode_t;

    // one of eight architectural registers
    typedef logic [`REG_IDX_W-1:0] regIdx_t;

    // register layout
    // alu and set ops name their second source in rt
    typedef struct packed {
        opcode_t    opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        // alu sub-operation select
        logic [1:0] func;
    } rFmt_t;

    // immediate layout
    // stores keep the data register in rd
    // so the second source sits where rt is in rFmt
    typedef struct packed {
        opcode_t    opcode;
        regIdx_t    rs;
        regIdx_t    rd;
        // 5-bit immediate, offset for loads and stores
        logic [4:0] imm5;
    } iFmt_t;

    // the fetched word, read through whichever layout fits the opcode
    // both views cover all 16 bits
    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
    } instWord_u;

endpackage

`default_nettype wire

// File: source_decoder.sv
/*
  Opcode decode for the hazard unit.
  Works out which source registers the fetched instruction reads and
  where their indexes sit in the word. Also flags the two opcodes that
  may pass while a branch is in flight. Purely combinational.
*/
`default_nettype none

`include "hazard_defs.svh"

module source_decoder (
    input  isa_pkg::instWord_u     fetchInst,
    output logic                   readsRs,
    output logic                   readsSecond,
    output logic                   branchExempt,
    output logic [`REG_IDX_W-1:0]  rsIdx,
    output logic [`REG_IDX_W-1:0]  secondIdx
);

    // opcode is at the same place in both layouts
    isa_pkg::opcode_t opcode;

    assign opcode = fetchInst.rFmt.opcode;

    // read class table
    always_comb begin
        readsRs     = 1'b1;
        readsSecond = 1'b0;

        casez (opcode)
            // stores read the address base and the data register
            `OP_ST, `OP_STU: begin
                readsSecond = 1'b1;
            end

            // two-source alu and set ops
            `OP_ARITH, `OP_BIT, 5'b111??: begin
                readsSecond = 1'b1;
            end

            // lbi, halt, nop, siic and rti read nothing
            `OP_LBI, `OP_HALT, `OP_NOP, `OP_SIIC, `OP_RTI: begin
                readsRs = 1'b0;
            end

            // j and jal take a displacement only
            5'b00100, 5'b00110: begin
                readsRs = 1'b0;
            end

            // everything else reads rs only
            // branches 011xx, jr/jalr 001x1, immediate alu, loads
            default: begin
                readsRs = 1'b1;
            end
        endcase
    end

    // siic and rti are let through behind a branch
    assign branchExempt = (opcode == `OP_SIIC) || (opcode == `OP_RTI);

    // rs is bits 10:8 in every layout
    assign rsIdx = fetchInst.rFmt.rs;

    // store data register (rd of the immediate layout) and alu rt
    // of the register layout both sit in bits 7:5
    assign secondIdx = fetchInst.rFmt.rt;

endmodule

`default_nettype wire

// File: operand_hazard.sv
/*
  Stall and forwarding decision for one source operand.
  Compares the operand's register index against the destinations of
  the D, X and M stages. Raises a stall on an M-stage match or a
  load-use, otherwise builds the 4-bit forwarding word.
*/
`default_nettype none

`include "hazard_defs.svh"

module operand_hazard (
    // the source operand
    input  logic [`REG_IDX_W-1:0] regIdx,
    input  logic                  readsReg,

    // producer write enables
    input  logic                  regWrtD,
    input  logic                  regWrtX,
    input  logic                  regWrtM,

    // producer destination registers
    input  logic [`REG_IDX_W-1:0] wrtRegD,
    input  logic [`REG_IDX_W-1:0] wrtRegX,
    input  logic [`REG_IDX_W-1:0] wrtRegM,

    // write-back source of the two forwardable producers
    input  logic [`WB_SEL_W-1:0]  wbDataSelD,
    input  logic [`WB_SEL_W-1:0]  wbDataSelX,

    output logic                  hazard,
    output logic [`FWD_W-1:0]     fwCntrl
);

    // per-stage match of this operand
    logic matchD;
    logic matchX;
    logic matchM;

    // D producer is a load, its data is not ready yet
    logic loadUse;

    // fields of the forwarding word
    logic                 fwdEn;
    logic                 fwdFromX;
    logic [`WB_SEL_W-1:0] fwdSrc;

    // a stage matches only when it actually writes
    assign matchD = regWrtD && (wrtRegD == regIdx);
    assign matchX = regWrtX && (wrtRegX == regIdx);
    assign matchM = regWrtM && (wrtRegM == regIdx);

    assign loadUse = matchD && (wbDataSelD == `WB_MEM);

    // M-stage producers have no forwarding path back to fetch
    // so they stall just like a load-use
    assign hazard = readsReg && (matchM || loadUse);

    // forward from D whenever it matches
    // X only counts when D is not a pending load
    assign fwdEn = matchD || (matchX && !loadUse);

    // 0 picks the D producer, 1 picks the X producer
    // the nearer stage always wins
    assign fwdFromX = !matchD;

    // data source follows the selected producer
    assign fwdSrc = matchD ? wbDataSelD : wbDataSelX;

    // word is all zero for an operand that is not read
    always_comb begin
        if (readsReg) begin
            fwCntrl = {fwdEn, fwdFromX, fwdSrc};
        end else begin
            fwCntrl = '0;
        end
    end

endmodule

`default_nettype wire

// File: hazard_unit.sv
/*
  Fetch-stage hazard unit for the five-stage pipeline.
  Decodes the fetched word, checks both source operands against the
  D, X and M producers and stalls on any branch in flight. On a stall
  or during reset a NOP goes forward instead of the fetched word.
  No state, so no clock.
*/
`default_nettype none

`include "hazard_defs.svh"

module hazard_unit (
    input  logic                  rst,
    input  logic [`INST_W-1:0]    fetchInst,

    // producer status from the younger stages
    input  logic                  regWrtD,
    input  logic                  regWrtX,
    input  logic                  regWrtM,
    input  logic [`REG_IDX_W-1:0] wrtRegD,
    input  logic [`REG_IDX_W-1:0] wrtRegX,
    input  logic [`REG_IDX_W-1:0] wrtRegM,
    input  logic [`WB_SEL_W-1:0]  wbDataSelD,
    input  logic [`WB_SEL_W-1:0]  wbDataSelX,

    // control flow ops still in the pipe
    input  logic                  branchInstD,
    input  logic                  branchInstX,
    input  logic                  branchInstM,
    input  logic                  branchInstW,

    output logic [`INST_W-1:0]    nextInst,
    output logic                  pcNop,
    output logic [`FWD_W-1:0]     fwCntrlA,
    output logic [`FWD_W-1:0]     fwCntrlB
);

    // fetched word seen through the isa layouts
    isa_pkg::instWord_u instWord;

    // decode results
    logic                  readsRs;
    logic                  readsSecond;
    logic                  branchExempt;
    logic [`REG_IDX_W-1:0] rsIdx;
    logic [`REG_IDX_W-1:0] secondIdx;

    // raw hazards per operand
    logic hazardA;
    logic hazardB;

    logic dataStall;
    logic branchInFlight;

    assign instWord = fetchInst;

    source_decoder dec0 (
        .fetchInst    (instWord),
        .readsRs      (readsRs),
        .readsSecond  (readsSecond),
        .branchExempt (branchExempt),
        .rsIdx        (rsIdx),
        .secondIdx    (secondIdx)
    );

    // operand A is always rs
    operand_hazard opA (
        .regIdx     (rsIdx),
        .readsReg   (readsRs),
        .regWrtD    (regWrtD),
        .regWrtX    (regWrtX),
        .regWrtM    (regWrtM),
        .wrtRegD    (wrtRegD),
        .wrtRegX    (wrtRegX),
        .wrtRegM    (wrtRegM),
        .wbDataSelD (wbDataSelD),
        .wbDataSelX (wbDataSelX),
        .hazard     (hazardA),
        .fwCntrl    (fwCntrlA)
    );

    // operand B is rt for alu ops, rd for stores
    operand_hazard opB (
        .regIdx     (secondIdx),
        .readsReg   (readsSecond),
        .regWrtD    (regWrtD),
        .regWrtX    (regWrtX),
        .regWrtM    (regWrtM),
        .wrtRegD    (wrtRegD),
        .wrtRegX    (wrtRegX),
        .wrtRegM    (wrtRegM),
        .wbDataSelD (wbDataSelD),
        .wbDataSelX (wbDataSelX),
        .hazard     (hazardB),
        .fwCntrl    (fwCntrlB)
    );

    assign dataStall = hazardA || hazardB;

    // any control op from decode through write-back
    assign branchInFlight = branchInstD || branchInstX || branchInstM || branchInstW;

    // siic and rti never stall
    assign pcNop = !branchExempt && (dataStall || branchInFlight);

    // bubble on stall and while in reset
    assign nextInst = (rst || pcNop) ? `NOP_INST : fetchInst;

endmodule

`default_nettype wire

// File: tb_clock.sv
/*
  Free-running clock for the hazard unit testbench, period 8.
*/
`default_nettype none

module tb_clock (
    output logic clk = 1'b0
);

    // half of the 8-unit period
    localparam int HALF = 4;

    // low from time zero, first rising edge at 4
    always #HALF clk = ~clk;

endmodule

`default_nettype wire

// File: hazard_unit_props.sv
/*
  Concurrent checks on the hazard unit outputs, bound into the DUT
  from the testbench. A stall or reset must send the NOP word, and
  siic or rti must never stall.
*/
`default_nettype none

`include "hazard_defs.svh"

module hazard_unit_props (
    input logic               clk,
    input logic               rst,
    input logic [`INST_W-1:0] fetchInst,
    input logic [`INST_W-1:0] nextInst,
    input logic               pcNop
);

    // fetched word through the package view
    isa_pkg::instWord_u instView;
    logic exemptOp;

    assign instView = fetchInst;
    assign exemptOp = (instView.rFmt.opcode == `OP_SIIC) || (instView.rFmt.opcode == `OP_RTI);

    // a stall hands the bubble forward
    stallSendsNop: assert property (@(posedge clk) pcNop |-> nextInst == `NOP_INST)
        else $error("pcNop high but nextInst is not the NOP word");

    // reset alone is enough for the bubble
    resetSendsNop: assert property (@(posedge clk) rst |-> nextInst == `NOP_INST)
        else $error("rst high but nextInst is not the NOP word");

    // siic and rti pass even behind a branch
    exemptNeverStalls: assert property (@(posedge clk) exemptOp |-> !pcNop)
        else $error("siic or rti raised pcNop");

endmodule

`default_nettype wire

// File: hazard_unit_tb.sv
/*
  Testbench for the fetch-stage hazard unit. Inputs change on the
  rising edge, all four outputs are compared on the falling edge with
  a reference model of the hazard rules. Directed tests come first,
  then a 300-vector random sweep. Built through tb.f.
*/
`default_nettype none

`include "hazard_defs.svh"

module hazard_unit_tb;

    // the tests need about 360 cycles
    localparam int MAX_CYCLES = 1000;
    localparam int RANDOM_VECTORS = 300;

    // producer that writes nothing, {write, reg, select}
    localparam logic [5:0] NO_PROD = 6'b0;

    logic clk;
    logic rst;
    logic [`INST_W-1:0] fetchInst;
    logic [`INST_W-1:0] nextInst;
    logic regWrtD, regWrtX, regWrtM;
    logic [`REG_IDX_W-1:0] wrtRegD, wrtRegX, wrtRegM;
    logic [`WB_SEL_W-1:0] wbDataSelD, wbDataSelX;
    logic branchInstD, branchInstX, branchInstM, branchInstW;
    logic pcNop;
    logic [`FWD_W-1:0] fwCntrlA, fwCntrlB;

    // expected {nextInst, pcNop, fwCntrlA, fwCntrlB}
    logic [24:0] expected;
    logic [31:0] rnd;
    logic [31:0] rndProd;
    integer seed;
    int cycleCount = 0;
    int checkCount = 0;
    int errorCount = 0;
    int testCount = 0;
    int errorsAtStart = 0;

    tb_clock clkGen (.clk(clk));

    hazard_unit dut0 (.*);

    bind hazard_unit hazard_unit_props props0 (
        .clk(hazard_unit_tb.clk), .rst(rst), .fetchInst(fetchInst),
        .nextInst(nextInst), .pcNop(pcNop)
    );

    // one source operand, returns {stall, forwarding word}
    function automatic logic [4:0] operandRef(input logic used, input logic [2:0] idx);
        logic hitD;
        logic hitX;
        logic hitM;
        logic pendingLoad;
        logic [3:0] fw;
        hitD = regWrtD && (wrtRegD == idx);
        hitX = regWrtX && (wrtRegX == idx);
        hitM = regWrtM && (wrtRegM == idx);
        pendingLoad = hitD && (wbDataSelD == `WB_MEM);
        fw = 4'b0;
        if (used) begin
            fw[3] = hitD || (hitX && !pendingLoad);
            // nearer producer wins, 1 means X
            fw[2] = !hitD;
            fw[1:0] = hitD ? wbDataSelD : wbDataSelX;
        end
        return {used && (hitM || pendingLoad), fw};
    endfunction

    // whole unit, from the opcode read classes down to the bubble
    function automatic logic [24:0] refModel();
        isa_pkg::instWord_u w;
        logic [4:0] op;
        logic useRs;
        logic useSecond;
        logic [2:0] secondReg;
        logic [4:0] resA;
        logic [4:0] resB;
        logic stall;
        w = fetchInst;
        op = w.rFmt.opcode;
        useRs = 1'b1;
        useSecond = 1'b0;
        secondReg = w.rFmt.rt;
        if (op == `OP_ST || op == `OP_STU) begin
            useSecond = 1'b1;
            secondReg = w.iFmt.rd;
        end else if (op == `OP_ARITH || op == `OP_BIT || op[4:2] == 3'b111) begin
            useSecond = 1'b1;
        end else if (op == `OP_LBI || op == `OP_HALT || op == `OP_NOP || op == `OP_SIIC ||
                     op == `OP_RTI || op == 5'b00100 || op == 5'b00110) begin
            useRs = 1'b0;
        end
        resA = operandRef(useRs, w.rFmt.rs);
        resB = operandRef(useSecond, secondReg);
        stall = resA[4] || resB[4] || branchInstD || branchInstX || branchInstM || branchInstW;
        // siic and rti are never held back
        if (op == `OP_SIIC || op == `OP_RTI) stall = 1'b0;
        return {(rst || stall) ? `NOP_INST : fetchInst, stall, resA[3:0], resB[3:0]};
    endfunction

    task automatic reportMismatch(input string what, input logic [15:0] got,
                                  input logic [15:0] want);
        $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, want);
        errorCount = errorCount + 1;
    endtask

    // producers are {write, reg, select}, M has no select
    task automatic applyVector(input logic [15:0] inst, input logic [3:0] br,
                               input logic [5:0] pD, input logic [5:0] pX,
                               input logic [3:0] pM);
        @(posedge clk);
        fetchInst <= inst;
        {branchInstD, branchInstX, branchInstM, branchInstW} <= br;
        {regWrtD, wrtRegD, wbDataSelD} <= pD;
        {regWrtX, wrtRegX, wbDataSelX} <= pX;
        {regWrtM, wrtRegM} <= pM;
    endtask

    // last falling-edge check is done by the next rising edge
    task automatic endTest(input string name);
        @(posedge clk);
        testCount = testCount + 1;
        $display("test %s: %0d mismatches", name, errorCount - errorsAtStart);
        errorsAtStart = errorCount;
    endtask

    // compare on every falling edge, also counts cycles
    always @(negedge clk) begin
        expected = refModel();
        checkCount = checkCount + 1;
        if (nextInst !== expected[24:9]) reportMismatch("nextInst", nextInst, expected[24:9]);
        if (pcNop !== expected[8]) reportMismatch("pcNop", {15'd0, pcNop}, {15'd0, expected[8]});
        if (fwCntrlA !== expected[7:4]) begin
            reportMismatch("fwCntrlA", {12'd0, fwCntrlA}, {12'd0, expected[7:4]});
        end
        if (fwCntrlB !== expected[3:0]) begin
            reportMismatch("fwCntrlB", {12'd0, fwCntrlB}, {12'd0, expected[3:0]});
        end
        cycleCount = cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        seed = 29;
        rst = 1'b1;
        fetchInst = `NOP_INST;
        {branchInstD, branchInstX, branchInstM, branchInstW} = 4'b0;
        {regWrtD, wrtRegD, wbDataSelD} = NO_PROD;
        {regWrtX, wrtRegX, wbDataSelX} = NO_PROD;
        {regWrtM, wrtRegM} = 4'b0;

        // any word fetched in reset turns into the NOP
        repeat (10) begin
            rnd = $random(seed);
            applyVector(rnd[15:0], rnd[19:16], rnd[25:20], rnd[31:26], rnd[23:20]);
        end
        endTest("reset");
        rst <= 1'b0;

        // rs from a D-stage alu result, rt from an X-stage immediate
        applyVector({`OP_ARITH, 3'd3, 3'd5, 5'd0}, 4'b0, {1'b1, 3'd3, `WB_ALU},
                    {1'b1, 3'd5, `WB_IMM}, 4'b0);
        endTest("forward");

        // load in D, then a plain M-stage match
        applyVector({`OP_ARITH, 3'd2, 3'd7, 5'd0}, 4'b0, {1'b1, 3'd2, `WB_MEM}, NO_PROD, 4'b0);
        applyVector({`OP_ARITH, 3'd1, 3'd4, 5'd0}, 4'b0, NO_PROD, NO_PROD, {1'b1, 3'd4});
        endTest("stall");

        // one branch flag at a time, then the exempt pair behind all four
        for (int i = 0; i < 4; i++) begin
            applyVector({5'b01000, 3'd1, 3'd0, 5'd0}, 4'b1 << i, NO_PROD, NO_PROD, 4'b0);
        end
        applyVector({`OP_SIIC, 3'd0, 3'd0, 5'd0}, 4'b1111, {1'b1, 3'd0, `WB_MEM}, NO_PROD, 4'b0);
        applyVector({`OP_RTI, 3'd0, 3'd0, 5'd0}, 4'b1111, {1'b1, 3'd0, `WB_MEM}, NO_PROD, 4'b0);
        endTest("branch");

        // read classes, r1 from D and r2 from X
        applyVector({`OP_LBI, 3'd1, 3'd2, 5'd0}, 4'b0, {1'b1, 3'd1, `WB_ALU},
                    {1'b1, 3'd2, `WB_IMM}, 4'b0);
        applyVector({5'b00100, 3'd1, 3'd2, 5'd0}, 4'b0, {1'b1, 3'd1, `WB_ALU},
                    {1'b1, 3'd2, `WB_IMM}, 4'b0);
        applyVector({5'b01100, 3'd2, 3'd1, 5'd0}, 4'b0, {1'b1, 3'd1, `WB_ALU},
                    {1'b1, 3'd2, `WB_IMM}, 4'b0);
        // store data register sits in rd, then a load feeding it
        applyVector({`OP_ST, 3'd2, 3'd1, 5'd0}, 4'b0, {1'b1, 3'd1, `WB_ALU},
                    {1'b1, 3'd2, `WB_IMM}, 4'b0);
        applyVector({`OP_ST, 3'd2, 3'd1, 5'd0}, 4'b0, {1'b1, 3'd1, `WB_MEM},
                    {1'b1, 3'd2, `WB_IMM}, 4'b0);
        endTest("classes");

        // branch flags only on one vector in eight
        repeat (RANDOM_VECTORS) begin
            rnd = $random(seed);
            rndProd = $random(seed);
            applyVector(rnd[15:0], (rnd[18:16] == 3'd0) ? rnd[22:19] : 4'b0,
                        rndProd[5:0], rndProd[11:6], rndProd[15:12]);
        end
        endTest("random");

        $display("summary: %0d tests, %0d checks, %0d mismatches",
                 testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
isa_pkg.sv
source_decoder.sv
operand_hazard.sv
hazard_unit.sv
tb_clock.sv
hazard_unit_props.sv
hazard_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the hazard unit testbench with Verilator and run it.
# Succeeds only when the simulation prints its pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module hazard_unit_tb -o simv \
    || { echo "verilator build failed"; exit 1; }
simOut="$(./obj_dir/simv 2>&1)"
echo "$simOut"
echo "$simOut" | grep -qx "No errors" && exit 0 || exit 1
